// ==== dv/gpu_line_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpu_line_asserts
	import gpu_line_pkg::*;
	(
		input logic clk,
		input logic rst,
		input comp_state_t state,
		input logic accept,
		input logic line_start,
		input logic line_busy,
		input logic pix_we,
		input logic [2:0] current_tile,
		input logic [2:0] last_tile
	);

	// Count of failed checks
	int failures = 0;

	////////////////////
	// Composer checks
	////////////////////

	// Idle never steps straight into a write state
	no_idle_write: assert property (@(posedge clk) disable iff (!rst)
		(state == s_idle) |=> !pix_we)
		else begin
			$error("line memory written straight out of idle");
			failures++;
		end

	// Accepted command shows up as busy on the next cycle
	busy_after_load: assert property (@(posedge clk) disable iff (!rst)
		(accept && !line_start) |=> line_busy)
		else begin
			$error("line_busy did not rise one cycle after an accepted load");
			failures++;
		end

	// Tile walk stays inside the commanded range
	tile_in_range: assert property (@(posedge clk) disable iff (!rst)
		line_busy |-> (current_tile <= last_tile))
		else begin
			$error("current_tile ran past the last tile of the sprite");
			failures++;
		end

endmodule

`default_nettype wire

// ==== dv/gpu_line_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpu_line_tb
	import gpu_line_pkg::*;
	();

	logic clk;
	logic rst;
	logic load;
	logic [9:0] addr;
	depth_t z;
	colour_t palette;
	logic [2:0] first;
	logic [2:0] last;
	logic line_busy;
	logic [2:0] current_tile;
	tile_t tile_data;
	logic line_start;
	logic [9:0] x;
	logic [9:0] y;
	logic [7:0] index;
	logic enable;

	integer seed;
	int errors;
	int tests_run;
	int tests_failed;

	// External tile memory answered in the same cycle
	tile_t tiles [8];

	// Reference line content for both halves
	logic m_cov [2][line_w];
	depth_t m_dep [2][line_w];
	logic [7:0] m_idx [2][line_w];

	assign tile_data = tiles[current_tile];

	gpu_line_top dut0 (
		.clk(clk),
		.rst(rst),
		.load(load),
		.addr(addr),
		.z(z),
		.palette(palette),
		.first(first),
		.last(last),
		.line_busy(line_busy),
		.current_tile(current_tile),
		.tile_data(tile_data),
		.line_start(line_start),
		.x(x),
		.y(y),
		.index(index),
		.enable(enable)
	);

	bind line_composer gpu_line_asserts asserts0 (
		.clk(clk),
		.rst(rst),
		.state(state),
		.accept(accept),
		.line_start(line_start),
		.line_busy(line_busy),
		.pix_we(pix_we),
		.current_tile(current_tile),
		.last_tile(last_tile)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	////////////////////
	// Helpers
	////////////////////

	function automatic int rand_below(input int n);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 32'(n));
	endfunction

	task automatic fill_tiles(input logic allow_zero);
		tile_t t;
		for (int i = 0; i < 8; i++) begin
			t = $random(seed);
			for (int p = 0; p < 8; p++) begin
				if (!allow_zero && t[4*p +: 4] == 4'd0) begin
					t[4*p +: 4] = 4'(p + 1);
				end
			end
			// Odd tiles get a transparent pair in the middle
			if (allow_zero && (i % 2) == 1) begin
				t[15:8] = 8'h00;
			end
			tiles[i] = t;
		end
	endtask

	function automatic void paint_model(input logic h, input int a, input depth_t zz,
			input colour_t pal, input int f, input int l);
		colour_t col;
		int px;
		for (int k = 0; k <= l - f; k++) begin
			for (int p = 0; p < 8; p++) begin
				col = tiles[f + k][4*p +: 4];
				px = a + 8 * k + p;
				// Colour 0 is see-through and equal or greater depth replaces
				if (col != 4'd0 && (!m_cov[h][px] || zz >= m_dep[h][px])) begin
					m_cov[h][px] = 1'b1;
					m_dep[h][px] = zz;
					m_idx[h][px] = {pal, col};
				end
			end
		end
	endfunction

	task automatic load_sprite(input logic [9:0] a, input depth_t zz, input colour_t pal,
			input logic [2:0] f, input logic [2:0] l);
		int waited;
		paint_model(y[0], int'(a), zz, pal, int'(f), int'(l));
		@(negedge clk);
		addr = a;
		z = zz;
		palette = pal;
		first = f;
		last = l;
		load = 1'b1;
		@(negedge clk);
		load = 1'b0;
		waited = 0;
		while (line_busy && waited < 100) begin
			@(negedge clk);
			waited++;
		end
		if (line_busy) begin
			$display("Timed out waiting for line_busy to fall after a sprite load");
			errors++;
		end
	endtask

	// Sprite kept fully inside the visible line
	task automatic random_sprite();
		int f;
		int l;
		int a;
		f = rand_below(8);
		l = f + rand_below(8 - f);
		a = rand_below(line_w - 8 * (l - f + 1) + 1);
		load_sprite(10'(a), 2'(rand_below(4)), 4'(rand_below(16)), 3'(f), 3'(l));
	endtask

	task automatic start_line();
		@(negedge clk);
		y = y + 10'd1;
		line_start = 1'b1;
		@(negedge clk);
		line_start = 1'b0;
		x = 10'd0;
	endtask

	task automatic check_pixel(input logic h, input int p);
		assert (enable === m_cov[h][p]) else begin
			$display("[ERROR] enable at x=%0d: got %h, expected %h", p, enable, m_cov[h][p]);
			errors++;
		end
		if (m_cov[h][p]) begin
			assert (index === m_idx[h][p]) else begin
				$display("[ERROR] index at x=%0d: got %h, expected %h", p, index, m_idx[h][p]);
				errors++;
			end
		end
		// Scanned pixels come back uncovered
		m_cov[h][p] = 1'b0;
	endtask

	// Result for x shows up one cycle after x is driven
	task automatic scan_line();
		logic h;
		h = ~y[0];
		for (int i = 1; i <= line_w; i++) begin
			@(negedge clk);
			check_pixel(h, i - 1);
			x = (i < line_w) ? 10'(i) : 10'h3ff;
		end
	endtask

	task automatic finish_test(input string name, input int mark);
		int n;
		n = errors - mark;
		tests_run++;
		if (n != 0) begin
			tests_failed++;
		end
		$display("%s: %s, %0d mismatches", name, (n == 0) ? "pass" : "fail", n);
	endtask

	////////////////////
	// Test sequence
	////////////////////

	initial begin
		int mark;
		int cnt;
		seed = 32'hecea9610;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		rst = 1'b0;
		load = 1'b0;
		addr = '0;
		z = '0;
		palette = '0;
		first = '0;
		last = '0;
		line_start = 1'b0;
		x = 10'h3ff;
		y = '0;
		for (int h = 0; h < 2; h++) begin
			for (int p = 0; p < line_w; p++) begin
				m_cov[h][p] = 1'b0;
			end
		end
		fill_tiles(1'b0);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;

		// Empty line straight after reset
		mark = errors;
		assert (line_busy === 1'b0) else begin
			$display("[ERROR] line_busy after reset: got %h, expected %h", line_busy, 1'b0);
			errors++;
		end
		assert (current_tile === 3'd0) else begin
			$display("[ERROR] current_tile after reset: got %h, expected %h", current_tile, 3'd0);
			errors++;
		end
		start_line();
		scan_line();
		finish_test("empty line after reset", mark);

		mark = errors;
		fill_tiles(1'b0);
		load_sprite(10'd128, 2'd2, 4'h5, 3'd1, 3'd4);
		start_line();
		scan_line();
		finish_test("aligned sprite", mark);

		// One line per pixel offset
		mark = errors;
		fill_tiles(1'b1);
		for (int o = 1; o < 4; o++) begin
			load_sprite(10'(4 * rand_below(100) + o), 2'd1, 4'(o + 8), 3'd0, 3'd2);
			start_line();
			scan_line();
		end
		finish_test("unaligned sprite", mark);

		mark = errors;
		fill_tiles(1'b1);
		load_sprite(10'd100, 2'd1, 4'h1, 3'd0, 3'd2);
		load_sprite(10'd105, 2'd1, 4'h2, 3'd3, 3'd4);
		load_sprite(10'd110, 2'd3, 4'h3, 3'd1, 3'd1);
		load_sprite(10'd98, 2'd2, 4'h4, 3'd5, 3'd7);
		load_sprite(10'd113, 2'd2, 4'h5, 3'd2, 3'd3);
		load_sprite(10'd101, 2'd3, 4'h6, 3'd6, 3'd6);
		start_line();
		scan_line();
		finish_test("overlapping depths", mark);

		// Compose the next line while the current one is shown
		mark = errors;
		fill_tiles(1'b0);
		load_sprite(10'd300, 2'd2, 4'h7, 3'd0, 3'd3);
		start_line();
		fork
			scan_line();
			begin
				load_sprite(10'd302, 2'd1, 4'h9, 3'd2, 3'd5);
				load_sprite(10'd50, 2'd0, 4'ha, 3'd0, 3'd1);
			end
		join
		start_line();
		scan_line();
		start_line();
		scan_line();
		finish_test("double buffer and clearing", mark);

		mark = errors;
		for (int n = 0; n < 20; n++) begin
			fill_tiles(1'b1);
			cnt = 1 + rand_below(6);
			for (int s = 0; s < cnt; s++) begin
				random_sprite();
			end
			start_line();
			scan_line();
		end
		finish_test("random lines", mark);

		// Failures of the bound composer checks
		if (dut0.comp0.asserts0.failures != 0) begin
			$display("Composer assertions failed %0d times", dut0.comp0.asserts0.failures);
			errors += dut0.comp0.asserts0.failures;
		end

		$display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== hw/gpu_line_pkg.sv ====
`default_nettype none

package gpu_line_pkg;

	////////////////////
	// Line geometry
	////////////////////

	// Visible pixels on one scan line
	localparam int line_w = 640;

	// Pixels packed into one line memory word
	localparam int pix_per_word = 4;

	// Word addresses per half of the double buffer
	localparam int words_per_line = line_w / pix_per_word;

	////////////////////
	// Word types
	////////////////////

	typedef logic [7:0] word_addr_t;

	// Sprite depth, larger is nearer
	typedef logic [1:0] depth_t;

	// Palette number or colour number
	typedef logic [3:0] colour_t;

	// Eight 4-bit colours, pixel 0 in the low nibble
	typedef logic [31:0] tile_t;

	// Four palette indices, palette in the high nibble of each byte
	typedef logic [31:0] pix_word_t;

	// Four 2-bit depths, one per pixel of a word
	typedef logic [7:0] depth_word_t;

	typedef logic [pix_per_word-1:0] cover_t;

	////////////////////
	// Composer FSM
	////////////////////

	typedef enum logic [2:0] {
		s_idle,
		s_start,
		s_first,
		s_wrfirst,
		s_second,
		s_wrsecond
	} comp_state_t;

endpackage

`default_nettype wire

// ==== hw/gpu_line_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpu_line_top
	import gpu_line_pkg::*;
	(
		input logic clk,
		input logic rst,

		input logic load,
		input logic [9:0] addr,
		input depth_t z,
		input colour_t palette,
		input logic [2:0] first,
		input logic [2:0] last,
		output logic line_busy,

		output logic [2:0] current_tile,
		input tile_t tile_data,

		input logic line_start,
		input logic [9:0] x,
		input logic [9:0] y,
		output logic [7:0] index,
		output logic enable
	);

	logic back_half;
	logic scan_half;
	logic [8:0] ram_addr;
	logic [8:0] scan_addr;
	logic pix_we;
	pix_word_t old_pix;
	pix_word_t new_pix;
	pix_word_t scan_pix;
	depth_word_t old_depth;
	depth_word_t new_depth;
	cover_t old_cover;
	cover_t new_cover;
	logic [1:0] x_lo;

	// Odd lines compose into half 1 while half 0 is shown
	assign back_half = y[0];
	assign scan_half = ~y[0];
	assign scan_addr = {scan_half, x[9:2]};

	// Byte select follows the registered word read
	always_ff @(posedge clk) begin
		x_lo <= x[1:0];
	end

	assign index = scan_pix[8*x_lo +: 8];

	line_composer comp0 (
		.clk(clk),
		.rst(rst),
		.load(load),
		.addr(addr),
		.z(z),
		.palette(palette),
		.first(first),
		.last(last),
		.back_half(back_half),
		.line_start(line_start),
		.line_busy(line_busy),
		.current_tile(current_tile),
		.tile_data(tile_data),
		.ram_addr(ram_addr),
		.pix_we(pix_we),
		.old_pix(old_pix),
		.old_depth(old_depth),
		.old_cover(old_cover),
		.new_pix(new_pix),
		.new_depth(new_depth),
		.new_cover(new_cover)
	);

	line_ram #(.word_t(pix_word_t)) pix_ram (
		.clk(clk),
		.a_addr(ram_addr),
		.a_din(new_pix),
		.a_we(pix_we),
		.a_dout(old_pix),
		.b_addr(scan_addr),
		.b_dout(scan_pix)
	);

	// Depths are only needed by the merge, port b stays open
	line_ram #(.word_t(depth_word_t)) depth_ram (
		.clk(clk),
		.a_addr(ram_addr),
		.a_din(new_depth),
		.a_we(pix_we),
		.a_dout(old_depth),
		.b_addr(scan_addr),
		.b_dout()
	);

	scanout_flags flags0 (
		.clk(clk),
		.rst(rst),
		.set_addr(ram_addr),
		.set_we(pix_we),
		.set_cover(new_cover),
		.look_addr(ram_addr),
		.look_cover(old_cover),
		.x(x),
		.scan_half(scan_half),
		.enable(enable)
	);

endmodule

`default_nettype wire

// ==== hw/line_composer.sv ====
`timescale 1ns/1ps
`default_nettype none

module line_composer
	import gpu_line_pkg::*;
	(
		input logic clk,
		input logic rst,

		// Sprite command
		input logic load,
		input logic [9:0] addr,
		input depth_t z,
		input colour_t palette,
		input logic [2:0] first,
		input logic [2:0] last,
		input logic back_half,

		input logic line_start,
		output logic line_busy,

		// Tile memory, answered in the same cycle
		output logic [2:0] current_tile,
		input tile_t tile_data,

		// Port a of both line memories and the coverage flags
		output logic [8:0] ram_addr,
		output logic pix_we,
		input pix_word_t old_pix,
		input depth_word_t old_depth,
		input cover_t old_cover,
		output pix_word_t new_pix,
		output depth_word_t new_depth,
		output cover_t new_cover
	);

	comp_state_t state;
	comp_state_t next_state;

	// Latched command
	word_addr_t word_addr;
	logic [1:0] offset;
	depth_t spr_z;
	colour_t spr_palette;
	logic [2:0] last_tile;
	logic half;

	// Set once all tiles are done and an unaligned tail word remains
	logic spill;

	logic [11:0] carry;
	logic [11:0] carry_out;
	tile_t merge_tile;
	logic second_half;
	logic tile_done;
	logic accept;

	assign accept = load && (state == s_idle);
	assign line_busy = (state != s_idle);
	assign tile_done = (current_tile == last_tile);

	////////////////////
	// FSM
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			state <= s_idle;
		end else if (line_start) begin
			state <= s_idle;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			s_idle: begin
				if (load) begin
					next_state = s_start;
				end
			end
			s_start: next_state = (current_tile > last_tile) ? s_idle : s_first;
			s_first: next_state = s_wrfirst;
			s_wrfirst: next_state = spill ? s_idle : s_second;
			s_second: next_state = s_wrsecond;
			s_wrsecond: begin
				if (!tile_done || offset != 2'd0) begin
					next_state = s_first;
				end else begin
					next_state = s_idle;
				end
			end
			default: next_state = s_idle;
		endcase
	end

	////////////////////
	// Command and walk
	////////////////////

	always_ff @(posedge clk) begin
		if (accept) begin
			offset <= addr[1:0];
			spr_z <= z;
			spr_palette <= palette;
			last_tile <= last;
			half <= back_half;
		end
	end

	// Next word after every write
	always_ff @(posedge clk) begin
		if (accept) begin
			word_addr <= addr[9:2];
		end else if (pix_we) begin
			word_addr <= word_addr + 8'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst) begin
			current_tile <= 3'd0;
			spill <= 1'b0;
		end else if (accept) begin
			current_tile <= first;
			spill <= 1'b0;
		end else if (state == s_wrsecond) begin
			// Stay on the last tile, the tail word reads no tile data
			if (tile_done) begin
				spill <= 1'b1;
			end else begin
				current_tile <= current_tile + 3'd1;
			end
		end
	end

	// Nothing carried into the first word of a sprite
	always_ff @(posedge clk) begin
		if (accept) begin
			carry <= 12'd0;
		end else if (state == s_wrsecond) begin
			carry <= carry_out;
		end
	end

	////////////////////
	// Merge and write
	////////////////////

	assign merge_tile = spill ? '0 : tile_data;
	assign second_half = (state == s_second) || (state == s_wrsecond);
	assign pix_we = (state == s_wrfirst) || (state == s_wrsecond);
	assign ram_addr = {half, word_addr};

	pixel_merge merge0 (
		.second_half(second_half),
		.offset(offset),
		.spr_z(spr_z),
		.spr_palette(spr_palette),
		.tile(merge_tile),
		.carry(carry),
		.old_pix(old_pix),
		.old_depth(old_depth),
		.old_cover(old_cover),
		.carry_out(carry_out),
		.new_pix(new_pix),
		.new_depth(new_depth),
		.new_cover(new_cover)
	);

endmodule

`default_nettype wire

// ==== hw/line_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

// Double buffer with the half select in the top address bit
module line_ram
	import gpu_line_pkg::*;
	#(
		parameter type word_t = pix_word_t
	)
	(
		input logic clk,

		// Composer side
		input logic [8:0] a_addr,
		input word_t a_din,
		input logic a_we,
		output word_t a_dout,

		// Scan-out side
		input logic [8:0] b_addr,
		output word_t b_dout
	);

	// One row of words per half
	word_t mem [2][words_per_line];

	// Old word for the merge stays stable across FIRST and its write cycle
	assign a_dout = mem[a_addr[8]][a_addr[7:0]];

	always_ff @(posedge clk) begin
		if (a_we) begin
			mem[a_addr[8]][a_addr[7:0]] <= a_din;
		end
	end

	// Registered read one cycle behind the scan position
	always_ff @(posedge clk) begin
		b_dout <= mem[b_addr[8]][b_addr[7:0]];
	end

endmodule

`default_nettype wire

// ==== hw/pixel_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_merge
	import gpu_line_pkg::*;
	(
		// Low or high four pixels of the tile
		input logic second_half,
		// Sprite x modulo 4
		input logic [1:0] offset,
		input depth_t spr_z,
		input colour_t spr_palette,
		input tile_t tile,
		// Pixels 5 to 7 of the previous tile
		input logic [11:0] carry,

		// Current content of the target word
		input pix_word_t old_pix,
		input depth_word_t old_depth,
		input cover_t old_cover,

		output logic [11:0] carry_out,
		output pix_word_t new_pix,
		output depth_word_t new_depth,
		output cover_t new_cover
	);

	////////////////////
	// Alignment
	////////////////////

	// Eleven nibbles, the three carried pixels below the eight tile pixels
	logic [43:0] stream;

	// Stream nibble that lands in slot 0 of this word
	logic [3:0] base;

	assign stream = {tile, carry};

	// Last three pixels can spill into the next tile's first word
	assign carry_out = tile[31:20];

	// Slot j takes nibble j + 3 - offset, four more on the second half.
	// Slots below the offset pick up the carry, which is colour 0
	// at the start of a sprite and so never overwrites anything.
	assign base = (second_half ? 4'd7 : 4'd3) - {2'b00, offset};

	////////////////////
	// Per-pixel merge
	////////////////////

	for (genvar j = 0; j < pix_per_word; j++) begin : g_slot
		colour_t colour;
		depth_t depth;
		logic hit;

		assign colour = stream[(base + j) * 4 +: 4];
		assign depth = old_depth[2*j +: 2];

		// Transparent pixels never hit, equal depth lets the newer sprite win
		assign hit = (colour != 4'd0) && (!old_cover[j] || spr_z >= depth);

		assign new_pix[8*j +: 8] = hit ? {spr_palette, colour} : old_pix[8*j +: 8];
		assign new_depth[2*j +: 2] = hit ? spr_z : depth;
		assign new_cover[j] = old_cover[j] | hit;
	end

endmodule

`default_nettype wire

// ==== hw/scanout_flags.sv ====
`timescale 1ns/1ps
`default_nettype none

module scanout_flags
	import gpu_line_pkg::*;
	(
		input logic clk,
		input logic rst,

		// Composer side works on whole words of the back half
		input logic [8:0] set_addr,
		input logic set_we,
		input cover_t set_cover,
		input logic [8:0] look_addr,
		output cover_t look_cover,

		// Scan-out side
		input logic [9:0] x,
		input logic scan_half,
		output logic enable
	);

	// One bit per pixel, grouped like the line memory words
	cover_t flags [2][words_per_line];

	logic in_line;
	logic [7:0] scan_word;
	logic [1:0] scan_bit;

	// Positions past the line edge neither read nor clear anything
	assign in_line = (x < line_w);
	assign scan_word = x[9:2];
	assign scan_bit = x[1:0];

	assign look_cover = flags[look_addr[8]][look_addr[7:0]];

	always_ff @(posedge clk) begin
		if (!rst) begin
			for (int h = 0; h < 2; h++) begin
				for (int i = 0; i < words_per_line; i++) begin
					flags[h][i] <= '0;
				end
			end
			enable <= 1'b0;
		end else begin
			if (set_we) begin
				flags[set_addr[8]][set_addr[7:0]] <= set_cover;
			end
			// Read and clear so the half comes back empty for the next compose
			if (in_line) begin
				flags[scan_half][scan_word][scan_bit] <= 1'b0;
			end
			enable <= in_line && flags[scan_half][scan_word][scan_bit];
		end
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hw/gpu_line_pkg.sv
hw/line_ram.sv
hw/pixel_merge.sv
hw/line_composer.sv
hw/scanout_flags.sv
hw/gpu_line_top.sv
dv/gpu_line_asserts.sv
dv/gpu_line_tb.sv
